//--- flist.f
source/lcd_pkg.sv
source/lcd_init_seq.sv
source/lcd_host_port.sv
source/lcd_cycle_engine.sv
source/lcd_ctrl_top.sv
tests/tb_lcd_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lcd controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_lcd_ctrl -f flist.f -o sim_lcd_ctrl
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/sim_lcd_ctrl)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "^TEST RESULT: PASS$"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- source/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top
	import lcd_pkg::*;
#(
	parameter int clk_per_us = 35
) (
	input  logic       clk,
	input  logic       arst_n,
	input  lcd_cfg_t   cfg,
	input  logic       req,
	input  logic [9:0] lcd_bus,	// rs, rw, data
	output logic       ack,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	lcd_cmd_t  init_cmd;
	logic      init_valid;
	logic      init_ready;
	logic      init_done;
	lcd_cmd_t  host_cmd;
	logic      host_valid;
	logic      host_ready;
	lcd_pins_t host_word;
	lcd_pins_t pins;
	logic      active;

	assign host_word = '{
		e:    1'b0,
		rs:   lcd_bus[9],
		rw:   lcd_bus[8],
		data: lcd_bus[7:0]
	};

	lcd_init_seq #(
		.clk_per_us (clk_per_us)
	) u_lcd_init_seq (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg        (cfg),
		.init_ready (init_ready),
		.init_cmd   (init_cmd),
		.init_valid (init_valid),
		.init_done  (init_done)
	);

	lcd_host_port u_lcd_host_port (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.lcd_bus    (host_word),
		.init_done  (init_done),
		.host_ready (host_ready),
		.ack        (ack),
		.host_cmd   (host_cmd),
		.host_valid (host_valid)
	);

	lcd_cycle_engine #(
		.clk_per_us (clk_per_us)
	) u_lcd_cycle_engine (
		.clk        (clk),
		.arst_n     (arst_n),
		.init_cmd   (init_cmd),
		.init_valid (init_valid),
		.host_cmd   (host_cmd),
		.host_valid (host_valid),
		.init_ready (init_ready),
		.host_ready (host_ready),
		.pins       (pins),
		.active     (active)
	);

	assign e        = pins.e;
	assign rs       = pins.rs;
	assign rw       = pins.rw;
	assign lcd_data = pins.data;

	assign busy = !init_done || active || host_valid;	// idle only after init with nothing queued

endmodule

//--- source/lcd_cycle_engine.sv
`timescale 1ns/1ps

module lcd_cycle_engine
	import lcd_pkg::*;
#(
	parameter int clk_per_us = 35
) (
	input  logic      clk,
	input  logic      arst_n,
	input  lcd_cmd_t  init_cmd,
	input  logic      init_valid,
	input  lcd_cmd_t  host_cmd,
	input  logic      host_valid,
	output logic      init_ready,
	output logic      host_ready,
	output lcd_pins_t pins,
	output logic      active
);

	// counter values, cycle 0 being the acceptance cycle
	localparam int e_rise  = setup_us * clk_per_us + 1;
	localparam int e_fall  = e_rise + e_high_us * clk_per_us;
	localparam int min_end = e_fall + e_low_us * clk_per_us;	// e low phase must fit

	lcd_cmd_t         cmd_q;
	logic             e_q;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] hold_cnt;
	logic [cnt_w-1:0] end_cnt;
	logic             take;

	// init always wins, host waits while an init command is offered
	assign init_ready = !active;
	assign host_ready = !active && !init_valid;
	assign take       = (init_valid && init_ready) || (host_valid && host_ready);

	always_comb begin
		hold_cnt = cnt_w'(int'(cmd_q.hold_us) * clk_per_us);
		if (hold_cnt < cnt_w'(min_end)) begin
			end_cnt = cnt_w'(min_end);	// hold shorter than the enable pulse
		end else begin
			end_cnt = hold_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cmd_q <= init_valid ? init_cmd : host_cmd;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			e_q    <= 1'b0;
			cnt    <= '0;
		end else if (!active) begin
			if (take) begin
				active <= 1'b1;
				cnt    <= cnt_w'(1);	// first driven cycle
			end
		end else begin
			cnt <= cnt + 1'b1;
			if (cnt == cnt_w'(e_rise - 1)) begin
				e_q <= 1'b1;
			end else if (cnt == cnt_w'(e_fall - 1)) begin
				e_q <= 1'b0;
			end
			if (cnt == end_cnt - 1'b1) begin
				active <= 1'b0;	// ready again on the next cycle
			end
		end
	end

	// address and data only while a cycle runs
	assign pins = '{
		e:    e_q,
		rs:   active & cmd_q.rs,
		rw:   active & cmd_q.rw,
		data: active ? cmd_q.data : 8'h00
	};

endmodule

//--- source/lcd_host_port.sv
`timescale 1ns/1ps

module lcd_host_port
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      req,
	input  lcd_pins_t lcd_bus,	// e field not used
	input  logic      init_done,
	input  logic      host_ready,
	output logic      ack,
	output lcd_cmd_t  host_cmd,
	output logic      host_valid
);

	typedef enum logic [1:0] {
		st_idle,
		st_pend,	// word captured, waiting for the engine
		st_ack		// ack high until the host drops req
	} state_t;

	state_t    state;
	lcd_pins_t word_q;

	// host holds the bus stable while req is high
	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			word_q <= lcd_bus;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (req) begin
						state <= st_pend;
					end
				end
				st_pend: begin
					if (host_valid && host_ready) begin
						state <= st_ack;
					end
				end
				st_ack: begin
					if (!req) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign ack        = (state == st_ack);
	assign host_valid = (state == st_pend) && init_done;	// held off until init ends

	assign host_cmd = '{
		rs:      word_q.rs,
		rw:      word_q.rw,
		data:    word_q.data,
		hold_us: 9'(host_hold_us)
	};

endmodule

//--- source/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq
	import lcd_pkg::*;
#(
	parameter int clk_per_us = 35
) (
	input  logic     clk,
	input  logic     arst_n,
	input  lcd_cfg_t cfg,
	input  logic     init_ready,
	output lcd_cmd_t init_cmd,
	output logic     init_valid,
	output logic     init_done
);

	localparam int power_cnt = power_up_us * clk_per_us;

	typedef enum logic [1:0] {
		st_power,	// waiting for the panel supply to settle
		st_cmd,		// offering the command of the current step
		st_last,	// entry mode sent, waiting for the engine
		st_done
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	logic [1:0]       step;
	logic [7:0]       cmd_data;

	// command byte of each step, built from the option bits
	always_comb begin
		case (step)
			2'd0: cmd_data = {4'b0011, cfg.two_lines, cfg.font_5x10, 2'b00};
			2'd1: cmd_data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on};
			2'd2: cmd_data = 8'b0000_0001;	// clear
			default: cmd_data = {6'b000001, cfg.increment, cfg.shift};
		endcase
	end

	assign init_cmd = '{
		rs:      1'b0,
		rw:      1'b0,
		data:    cmd_data,
		hold_us: init_hold_us[step]
	};

	assign init_valid = (state == st_cmd);
	assign init_done  = (state == st_done);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_power;
			cnt   <= '0;
			step  <= '0;
		end else begin
			case (state)
				st_power: begin
					if (cnt == cnt_w'(power_cnt - 1)) begin
						cnt   <= '0;
						state <= st_cmd;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_cmd: begin
					if (init_ready) begin	// transfer this cycle
						if (step == 2'd3) begin
							state <= st_last;
						end else begin
							step <= step + 1'b1;
						end
					end
				end
				st_last: begin
					// engine is busy right after the transfer, so ready here
					// means the entry mode hold has run out
					if (init_ready) begin
						state <= st_done;
					end
				end
				default: begin
					state <= st_done;
				end
			endcase
		end
	end

endmodule

//--- source/lcd_pkg.sv
package lcd_pkg;

	// panel option bits, msb first as on the cfg input
	typedef struct packed {
		logic two_lines;	// N bit of function set
		logic font_5x10;	// F bit
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;	// I/D bit of entry mode
		logic shift;
	} lcd_cfg_t;

	// one bus cycle request
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
		logic [8:0] hold_us;	// whole cycle length, from start of setup
	} lcd_cmd_t;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	localparam int cnt_w = 16;	// timing counter width

	localparam int power_up_us  = 500;
	localparam int setup_us     = 1;	// address setup before e rises
	localparam int e_high_us    = 13;
	localparam int e_low_us     = 13;
	localparam int host_hold_us = 50;

	// function set, display control, clear, entry mode
	localparam logic [3:0][8:0] init_hold_us = {
		9'd110,
		9'd210,
		9'd60,
		9'd60
	};

endpackage

//--- tests/tb_lcd_ctrl.sv
`timescale 1ns/1ps

module tb_lcd_ctrl
	import lcd_pkg::*;
;

	localparam int k       = 2;	// clk_per_us of the DUT
	localparam int n_host  = 8;
	localparam int n_pulse = n_host + 4;
	localparam int init_sum_us = int'(init_hold_us[0]) + int'(init_hold_us[1])
		+ int'(init_hold_us[2]) + int'(init_hold_us[3]);
	localparam int timeout_cycles =
		(power_up_us + init_sum_us + host_hold_us * n_host) * k * 2;

	// test ids
	localparam int t_init  = 0;
	localparam int t_width = 1;
	localparam int t_host  = 2;
	localparam int t_hs    = 3;
	localparam int t_space = 4;
	localparam int t_busy  = 5;

	logic       clk = 1'b0;
	logic       arst_n;
	lcd_cfg_t   cfg;
	logic       req;
	logic [9:0] lcd_bus;
	logic       ack;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;

	logic [9:0] host_words [n_host];
	lcd_pins_t  samples [$];	// pins just before each fall of e
	lcd_pins_t  pin_now;
	lcd_pins_t  pin_prev = '0;
	lcd_pins_t  pin_setup = '0;	// pins one cycle before e rose
	logic       ack_prev = 1'b0;
	logic       data_moved = 1'b0;
	logic       compare_done = 1'b0;
	int         cyc = 0;
	int         high_cnt = 0;
	int         pulses = 0;
	int         ack_rises = 0;
	int         last_host_rise = -1;
	int         n_checks = 0;
	int         err_cnt [6] = '{default: 0};
	string      test_name [6] = '{"init_sequence", "enable_width", "host_words",
		"handshake", "spacing", "busy"};

	lcd_ctrl_top #(
		.clk_per_us (k)
	) u_lcd_ctrl_top (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg      (cfg),
		.req      (req),
		.lcd_bus  (lcd_bus),
		.ack      (ack),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.busy     (busy)
	);

	always #4 clk = ~clk;

	// expected pins at the fall of e for pulse idx
	function automatic lcd_pins_t expected_pins(input lcd_cfg_t c, input logic [9:0] word,
		input int idx);
		lcd_pins_t p;
		p.e  = 1'b1;
		p.rs = 1'b0;
		p.rw = 1'b0;
		case (idx)
			0: p.data = {4'b0011, c.two_lines, c.font_5x10, 2'b00};	// function set
			1: p.data = {5'b00001, c.display_on, c.cursor_on, c.blink_on};
			2: p.data = 8'h01;	// clear
			3: p.data = {6'b000001, c.increment, c.shift};
			default: begin
				p.rs   = word[9];
				p.rw   = word[8];
				p.data = word[7:0];
			end
		endcase
		return p;
	endfunction

	function automatic string pins_text(input lcd_pins_t p);
		return $sformatf("e=%b rs=%b rw=%b data=%h", p.e, p.rs, p.rw, p.data);
	endfunction

	task automatic check_pins(input lcd_pins_t got, input lcd_pins_t exp, input int test_id,
		input string what);
		n_checks++;
		if (got !== exp) begin
			err_cnt[test_id]++;
			$display("Mismatch at %0t: %s got %s, expected %s", $time, what,
				pins_text(got), pins_text(exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input int test_id,
		input string what);
		n_checks++;
		if (got != exp) begin
			err_cnt[test_id]++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input int test_id,
		input string what);
		n_checks++;
		if (got !== exp) begin
			err_cnt[test_id]++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic flag_error(input int test_id, input string what);
		n_checks++;
		err_cnt[test_id]++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic print_test_line(input int test_id);
		$display("test %-14s %s (%0d errors)", test_name[test_id],
			(err_cnt[test_id] == 0) ? "passed" : "failed", err_cnt[test_id]);
	endtask

	// four-phase master side of the host bus
	task automatic send_word(input logic [9:0] w);
		@(posedge clk);
		req     <= 1'b1;
		lcd_bus <= w;
		do begin
			@(negedge clk);
		end while (!ack);
		@(posedge clk);
		req <= 1'b0;
		do begin
			@(negedge clk);
		end while (ack);
	endtask

	// pin monitor, sampled away from the active edge
	always @(negedge clk) begin
		pin_now = '{e: e, rs: rs, rw: rw, data: lcd_data};
		if (!arst_n) begin
			check_pins(pin_now, '0, t_busy, "pins while reset is held");
			compare_bit(busy, 1'b1, t_busy, "busy while reset is held");
			compare_bit(ack, 1'b0, t_busy, "ack while reset is held");
		end else begin
			if (pin_now.e && !pin_prev.e) begin
				high_cnt   = 0;
				data_moved = 1'b0;
				pin_setup  = pin_prev;
				if (pulses >= 4 && last_host_rise >= 0) begin
					n_checks++;
					if (cyc - last_host_rise < host_hold_us * k) begin
						err_cnt[t_space]++;
						$display("Mismatch at %0t: host e rises %0d cycles apart, min %0d",
							$time, cyc - last_host_rise, host_hold_us * k);
					end
				end
				if (pulses >= 4)
					last_host_rise = cyc;	// host cycle
			end
			if (pin_now.e) begin
				high_cnt++;
				if (pin_now.rs != pin_setup.rs || pin_now.rw != pin_setup.rw
					|| pin_now.data != pin_setup.data)
					data_moved = 1'b1;
			end
			if (!pin_now.e && pin_prev.e) begin
				samples.push_back(pin_prev);
				check_count(high_cnt, e_high_us * k, t_width, "e high width in cycles");
				if (data_moved)
					flag_error(t_width, "rs, rw or data changed before the fall of e");
				pulses++;
			end
			if (ack && !ack_prev) begin
				ack_rises++;
				if (pulses < 4)
					flag_error(t_hs, "ack rose before the init sequence ended");
			end
			if (pulses < 4)
				compare_bit(busy, 1'b1, t_busy, "busy during the init sequence");
		end
		pin_prev = pin_now;
		ack_prev = ack;
	end

	// compare process
	initial begin
		lcd_pins_t  got;
		lcd_pins_t  exp;
		logic [9:0] w;
		for (int idx = 0; idx < n_pulse; idx++) begin
			while (samples.size() == 0)
				@(posedge clk);
			got = samples.pop_front();
			w   = (idx < 4) ? 10'h000 : host_words[idx - 4];
			exp = expected_pins(cfg, w, idx);
			check_pins(got, exp, (idx < 4) ? t_init : t_host, $sformatf("pulse %0d", idx));
			if (idx == 3)
				print_test_line(t_init);
		end
		print_test_line(t_host);
		compare_done = 1'b1;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= timeout_cycles) begin
			$display("Error: timeout, the run did not finish within %0d cycles",
				timeout_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int total;
		void'($urandom(32'h679001ef));
		cfg = lcd_cfg_t'(7'($urandom));
		for (int i = 0; i < n_host; i++)
			host_words[i] = 10'($urandom);
		req     = 1'b0;
		lcd_bus = 10'h000;
		arst_n  = 1'b1;
		#1;
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		// first req goes up while init still runs
		for (int i = 0; i < n_host; i++) begin
			send_word(host_words[i]);
			repeat ($urandom_range(3)) @(posedge clk);
		end
		while (!compare_done)
			@(posedge clk);
		repeat (2 * host_hold_us * k) @(posedge clk);	// last host cycle runs out
		@(negedge clk);
		check_count(pulses, n_pulse, t_width, "number of e pulses");
		check_count(ack_rises, n_host, t_hs, "number of ack pulses");
		compare_bit(busy, 1'b0, t_busy, "busy with the bus idle after init");
		check_pins('{e: e, rs: rs, rw: rw, data: lcd_data}, '0, t_busy, "idle pins");
		print_test_line(t_width);
		print_test_line(t_hs);
		print_test_line(t_space);
		print_test_line(t_busy);
		total = 0;
		for (int i = 0; i < 6; i++)
			total += err_cnt[i];
		$display("checks: %0d, errors: %0d", n_checks, total);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
